// File: common/dcfifo_defines.svh
// Dual-clock streaming FIFO constants
// Depth, synchronizer length, beat field widths and CSR map

`ifndef DCFIFO_DEFINES_SVH
`define DCFIFO_DEFINES_SVH

// Storage, a power of two
`define DCFIFO_DEPTH        16
`define DCFIFO_ADDR_W       4

// Flip-flops per pointer synchronizer chain
`define DCFIFO_SYNC_DEPTH   2

// Beat fields
`define DCFIFO_DATA_W       32
`define DCFIFO_EMPTY_W      2

// CSR port
`define DCFIFO_THRESH_W     24
`define DCFIFO_CSR_W        32
`define DCFIFO_ADDR_FILL    1'b0
`define DCFIFO_ADDR_THRESH  1'b1

`endif

// File: common/dcfifo_pkg.sv
// Dual-clock streaming FIFO shared types
// Beat payload, pointers, fill level and CSR request

`include "dcfifo_defines.svh"

package dcfifo_pkg;

    // ------------------------------------------------------------
    // Streaming payload
    // ------------------------------------------------------------

    // One stored beat with packet framing
    typedef struct packed {
        logic [`DCFIFO_DATA_W-1:0]  data;
        logic                       sop;
        logic                       eop;
        // Unused symbols in the last beat of a packet
        logic [`DCFIFO_EMPTY_W-1:0] empty;
    } beat_t;

    // ------------------------------------------------------------
    // Pointers and levels
    // ------------------------------------------------------------

    // Extra top bit tells full from empty when addresses match
    typedef logic [`DCFIFO_ADDR_W:0] ptr_t;

    // Wide enough for depth plus the output stage
    typedef logic [`DCFIFO_ADDR_W:0] fill_t;

    // ------------------------------------------------------------
    // Control/status register port
    // ------------------------------------------------------------

    // Request from the environment, read data returns separately
    typedef struct packed {
        logic                     address;
        logic                     read;
        logic                     write;
        logic [`DCFIFO_CSR_W-1:0] writedata;
    } csr_req_t;

endpackage

// File: hw/gray_ptr_sync.sv
// Pointer clock crossing
// Gray-encodes a binary pointer in the source domain, hardens it
// through a synchronizer chain and decodes it in the destination

`timescale 1ns/1ps

`include "dcfifo_defines.svh"

module gray_ptr_sync
    import dcfifo_pkg::*;
(
    input  logic src_clk,
    input  logic src_reset_n,
    input  ptr_t src_ptr,
    input  logic dst_clk,
    input  logic dst_reset_n,
    output ptr_t dst_ptr
);

    ptr_t src_gray;
    ptr_t sync_q [`DCFIFO_SYNC_DEPTH];

    function automatic ptr_t gray2bin(input ptr_t gray);
        ptr_t bin;
        bin[$bits(ptr_t)-1] = gray[$bits(ptr_t)-1];
        for (int i = $bits(ptr_t) - 2; i >= 0; i--) begin
            bin[i] = bin[i+1] ^ gray[i];
        end
        return bin;
    endfunction

    // Registered encode so only one bit can move per source edge
    always_ff @(posedge src_clk or negedge src_reset_n) begin
        if (!src_reset_n) begin
            src_gray <= '0;
        end else begin
            src_gray <= src_ptr ^ (src_ptr >> 1);
        end
    end

    always_ff @(posedge dst_clk or negedge dst_reset_n) begin
        if (!dst_reset_n) begin
            for (int i = 0; i < `DCFIFO_SYNC_DEPTH; i++) begin
                sync_q[i] <= '0;
            end
        end else begin
            sync_q[0] <= src_gray;
            for (int i = 1; i < `DCFIFO_SYNC_DEPTH; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    assign dst_ptr = gray2bin(sync_q[`DCFIFO_SYNC_DEPTH-1]);

    // The crossing is only safe if the sampled code never jumps
    a_gray_one_bit: assert property (
        @(posedge src_clk) disable iff (!src_reset_n)
        $countones(src_gray ^ $past(src_gray)) <= 1
    );

endmodule

// File: hw/dcfifo_mem.sv
// Beat storage for the dual-clock FIFO
// Synchronous write on the write clock, registered read on the read clock

`timescale 1ns/1ps

`include "dcfifo_defines.svh"

module dcfifo_mem
    import dcfifo_pkg::*;
(
    input  logic                      wr_clk,
    input  logic                      wr_en,
    input  logic [`DCFIFO_ADDR_W-1:0] wr_addr,
    input  beat_t                     wr_beat,
    input  logic                      rd_clk,
    input  logic [`DCFIFO_ADDR_W-1:0] rd_addr,
    output beat_t                     rd_beat
);

    beat_t mem [`DCFIFO_DEPTH];

    always_ff @(posedge wr_clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_beat;
        end
    end

    // Address is the next read pointer, so data lines up with it
    always_ff @(posedge rd_clk) begin
        rd_beat <= mem[rd_addr];
    end

endmodule

// File: hw/level_csr.sv
// Fill-level CSR and threshold status for one FIFO side
// Address 0 reads the fill level, address 1 holds a 24-bit threshold,
// and a streaming bit compares the two every cycle

`timescale 1ns/1ps

`include "dcfifo_defines.svh"

module level_csr
    import dcfifo_pkg::*;
#(
    // 1 flags fill at or above threshold, 0 flags at or below
    parameter bit ABOVE = 1'b1
) (
    input  logic                     clk,
    input  logic                     reset_n,
    input  fill_t                    fill,
    input  csr_req_t                 csr,
    output logic [`DCFIFO_CSR_W-1:0] readdata,
    output logic                     status_valid,
    output logic                     status_data
);

    logic [`DCFIFO_THRESH_W-1:0] threshold;
    logic [`DCFIFO_THRESH_W-1:0] fill_ext;
    logic                        over;

    assign fill_ext = {{(`DCFIFO_THRESH_W - $bits(fill_t)){1'b0}}, fill};
    assign over     = ABOVE ? (fill_ext >= threshold) : (fill_ext <= threshold);

    // ------------------------------------------------------------
    // Register access
    // ------------------------------------------------------------

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            threshold <= '0;
            readdata  <= '0;
        end else if (csr.write) begin
            // Writes win over a read in the same cycle
            if (csr.address == `DCFIFO_ADDR_THRESH) begin
                threshold <= csr.writedata[`DCFIFO_THRESH_W-1:0];
            end
        end else if (csr.read) begin
            // Upper bits are reserved
            readdata <= '0;
            if (csr.address == `DCFIFO_ADDR_FILL) begin
                readdata[`DCFIFO_THRESH_W-1:0] <= fill_ext;
            end else begin
                readdata[`DCFIFO_THRESH_W-1:0] <= threshold;
            end
        end
    end

    // ------------------------------------------------------------
    // Streaming status
    // ------------------------------------------------------------

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            status_valid <= 1'b0;
            status_data  <= 1'b0;
        end else begin
            status_valid <= 1'b1;
            status_data  <= over;
        end
    end

endmodule

// File: hw/write_side/dcfifo_write_ctrl.sv
// Write-side control of the dual-clock FIFO
// Write pointer, registered full flag, input fill level and the
// almost-full CSR on the in_clk domain

`timescale 1ns/1ps

`include "dcfifo_defines.svh"

module dcfifo_write_ctrl
    import dcfifo_pkg::*;
(
    input  logic                      in_clk,
    input  logic                      in_reset_n,
    input  logic                      in_valid,
    output logic                      in_ready,
    output logic                      wr_en,
    output logic [`DCFIFO_ADDR_W-1:0] wr_addr,
    output ptr_t                      wr_ptr,
    input  ptr_t                      rd_ptr_sync,
    input  csr_req_t                  in_csr,
    output logic [`DCFIFO_CSR_W-1:0]  in_csr_readdata,
    output logic                      almost_full_valid,
    output logic                      almost_full_data
);

    ptr_t  next_wr_ptr;
    logic  full;
    fill_t in_fill;

    assign in_ready    = !full;
    assign wr_en       = in_valid && in_ready;
    assign wr_addr     = wr_ptr[`DCFIFO_ADDR_W-1:0];
    assign next_wr_ptr = wr_ptr + ptr_t'(wr_en);

    // ------------------------------------------------------------
    // Pointer, full flag and fill level
    // ------------------------------------------------------------

    // Read pointer arrives late, so full errs on the safe side
    always_ff @(posedge in_clk or negedge in_reset_n) begin
        if (!in_reset_n) begin
            wr_ptr  <= '0;
            full    <= 1'b0;
            in_fill <= '0;
        end else begin
            wr_ptr  <= next_wr_ptr;
            full    <= (next_wr_ptr[`DCFIFO_ADDR_W-1:0] == rd_ptr_sync[`DCFIFO_ADDR_W-1:0])
                    && (next_wr_ptr[`DCFIFO_ADDR_W] != rd_ptr_sync[`DCFIFO_ADDR_W]);
            // Memory only, the output stage is not seen from here
            in_fill <= next_wr_ptr - rd_ptr_sync;
        end
    end

    level_csr #(
        .ABOVE (1'b1)
    ) in_csr_inst (
        .clk          (in_clk),
        .reset_n      (in_reset_n),
        .fill         (in_fill),
        .csr          (in_csr),
        .readdata     (in_csr_readdata),
        .status_valid (almost_full_valid),
        .status_data  (almost_full_data)
    );

    // A write must always land in a free slot of memory
    a_no_write_when_full: assert property (
        @(posedge in_clk) disable iff (!in_reset_n)
        wr_en |-> (ptr_t'(wr_ptr - rd_ptr_sync) < `DCFIFO_DEPTH)
    );

endmodule

// File: hw/read_side/dcfifo_read_ctrl.sv
// Read-side control of the dual-clock FIFO
// Read pointer, registered empty flag, output register stage, output
// fill level and the almost-empty CSR on the out_clk domain

`timescale 1ns/1ps

`include "dcfifo_defines.svh"

module dcfifo_read_ctrl
    import dcfifo_pkg::*;
(
    input  logic                      out_clk,
    input  logic                      out_reset_n,
    input  ptr_t                      wr_ptr_sync,
    output logic [`DCFIFO_ADDR_W-1:0] rd_addr,
    output ptr_t                      rd_ptr,
    input  beat_t                     mem_beat,
    output beat_t                     out_beat,
    output logic                      out_valid,
    input  logic                      out_ready,
    input  csr_req_t                  out_csr,
    output logic [`DCFIFO_CSR_W-1:0]  out_csr_readdata,
    output logic                      almost_empty_valid,
    output logic                      almost_empty_data
);

    ptr_t  next_rd_ptr;
    logic  empty;
    logic  stage_ready;
    logic  rd_take;
    fill_t fifo_fill;
    fill_t out_fill;

    // Stage loads when it is free or its beat leaves this cycle
    assign stage_ready = out_ready || !out_valid;
    assign rd_take     = stage_ready && !empty;
    assign next_rd_ptr = rd_ptr + ptr_t'(rd_take);
    assign rd_addr     = next_rd_ptr[`DCFIFO_ADDR_W-1:0];

    // ------------------------------------------------------------
    // Pointer, empty flag and memory fill level
    // ------------------------------------------------------------

    always_ff @(posedge out_clk or negedge out_reset_n) begin
        if (!out_reset_n) begin
            rd_ptr    <= '0;
            empty     <= 1'b1;
            fifo_fill <= '0;
        end else begin
            rd_ptr    <= next_rd_ptr;
            // Synced write pointer lags, so empty is pessimistic
            empty     <= (next_rd_ptr == wr_ptr_sync);
            fifo_fill <= wr_ptr_sync - next_rd_ptr;
        end
    end

    // ------------------------------------------------------------
    // Output stage
    // ------------------------------------------------------------

    always_ff @(posedge out_clk or negedge out_reset_n) begin
        if (!out_reset_n) begin
            out_valid <= 1'b0;
        end else if (stage_ready) begin
            out_valid <= !empty;
        end
    end

    always_ff @(posedge out_clk) begin
        if (stage_ready) begin
            out_beat <= mem_beat;
        end
    end

    // Count the beat held in the stage as well
    assign out_fill = fifo_fill + fill_t'(out_valid);

    level_csr #(
        .ABOVE (1'b0)
    ) out_csr_inst (
        .clk          (out_clk),
        .reset_n      (out_reset_n),
        .fill         (out_fill),
        .csr          (out_csr),
        .readdata     (out_csr_readdata),
        .status_valid (almost_empty_valid),
        .status_data  (almost_empty_data)
    );

    // A read must only take a slot that holds a written beat
    a_read_holds_beat: assert property (
        @(posedge out_clk) disable iff (!out_reset_n)
        rd_take |-> (ptr_t'(wr_ptr_sync - rd_ptr) != '0)
    );

endmodule

// File: hw/dcfifo_top.sv
// Dual-clock streaming FIFO with packet framing
// Write side on in_clk, read side on out_clk, joined by the beat
// memory and two Gray-coded pointer crossers

`timescale 1ns/1ps

`include "dcfifo_defines.svh"

module dcfifo_top
    import dcfifo_pkg::*;
(
    input  logic                     in_clk,
    input  logic                     in_reset_n,
    input  logic                     out_clk,
    input  logic                     out_reset_n,
    // Input stream
    input  beat_t                    in_beat,
    input  logic                     in_valid,
    output logic                     in_ready,
    // Output stream
    output beat_t                    out_beat,
    output logic                     out_valid,
    input  logic                     out_ready,
    // CSR ports
    input  csr_req_t                 in_csr,
    input  csr_req_t                 out_csr,
    output logic [`DCFIFO_CSR_W-1:0] in_csr_readdata,
    output logic [`DCFIFO_CSR_W-1:0] out_csr_readdata,
    // Streaming status
    output logic                     almost_full_valid,
    output logic                     almost_full_data,
    output logic                     almost_empty_valid,
    output logic                     almost_empty_data
);

    logic                      wr_en;
    logic [`DCFIFO_ADDR_W-1:0] wr_addr;
    logic [`DCFIFO_ADDR_W-1:0] rd_addr;
    ptr_t                      wr_ptr;
    ptr_t                      rd_ptr;
    ptr_t                      wr_ptr_sync;
    ptr_t                      rd_ptr_sync;
    beat_t                     mem_beat;

    dcfifo_write_ctrl write_ctrl_inst (
        .in_clk            (in_clk),
        .in_reset_n        (in_reset_n),
        .in_valid          (in_valid),
        .in_ready          (in_ready),
        .wr_en             (wr_en),
        .wr_addr           (wr_addr),
        .wr_ptr            (wr_ptr),
        .rd_ptr_sync       (rd_ptr_sync),
        .in_csr            (in_csr),
        .in_csr_readdata   (in_csr_readdata),
        .almost_full_valid (almost_full_valid),
        .almost_full_data  (almost_full_data)
    );

    dcfifo_mem mem_inst (
        .wr_clk  (in_clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_beat (in_beat),
        .rd_clk  (out_clk),
        .rd_addr (rd_addr),
        .rd_beat (mem_beat)
    );

    // Write pointer into the read domain
    gray_ptr_sync write_crosser (
        .src_clk     (in_clk),
        .src_reset_n (in_reset_n),
        .src_ptr     (wr_ptr),
        .dst_clk     (out_clk),
        .dst_reset_n (out_reset_n),
        .dst_ptr     (wr_ptr_sync)
    );

    // Read pointer back into the write domain
    gray_ptr_sync read_crosser (
        .src_clk     (out_clk),
        .src_reset_n (out_reset_n),
        .src_ptr     (rd_ptr),
        .dst_clk     (in_clk),
        .dst_reset_n (in_reset_n),
        .dst_ptr     (rd_ptr_sync)
    );

    dcfifo_read_ctrl read_ctrl_inst (
        .out_clk            (out_clk),
        .out_reset_n        (out_reset_n),
        .wr_ptr_sync        (wr_ptr_sync),
        .rd_addr            (rd_addr),
        .rd_ptr             (rd_ptr),
        .mem_beat           (mem_beat),
        .out_beat           (out_beat),
        .out_valid          (out_valid),
        .out_ready          (out_ready),
        .out_csr            (out_csr),
        .out_csr_readdata   (out_csr_readdata),
        .almost_empty_valid (almost_empty_valid),
        .almost_empty_data  (almost_empty_data)
    );

endmodule

// File: test/dcfifo_tb.sv
// Testbench for the dual-clock streaming FIFO
// Random traffic with order check, back-pressure, CSR and status checks

`timescale 1ns/1ps

`include "dcfifo_defines.svh"

module dcfifo_tb
    import dcfifo_pkg::*;
;

    localparam int  IN_HALF      = 20;
    localparam int  OUT_HALF     = 28;
    localparam int  N_BEATS      = 400;
    localparam bit  IN_SIDE      = 1'b0;
    localparam bit  OUT_SIDE     = 1'b1;
    localparam int  READY_RANDOM = 0;
    localparam int  READY_LOW    = 1;
    localparam int  READY_HIGH   = 2;
    // Roughly four output cycles per beat plus the fixed phases
    localparam time TEST_LEN_NS  = (N_BEATS * 4 + 600) * 2 * OUT_HALF;

    logic                     in_clk;
    logic                     in_reset_n;
    logic                     out_clk;
    logic                     out_reset_n;
    beat_t                    in_beat;
    logic                     in_valid;
    logic                     in_ready;
    beat_t                    out_beat;
    logic                     out_valid;
    logic                     out_ready;
    csr_req_t                 in_csr;
    csr_req_t                 out_csr;
    logic [`DCFIFO_CSR_W-1:0] in_csr_readdata;
    logic [`DCFIFO_CSR_W-1:0] out_csr_readdata;
    logic                     almost_full_valid;
    logic                     almost_full_data;
    logic                     almost_empty_valid;
    logic                     almost_empty_data;

    beat_t       sent_q[$];
    int          ready_mode;
    int          error_count;
    int          check_count;
    logic [31:0] in_rng;
    logic [31:0] out_rng;

    dcfifo_top dcfifo_top_inst (.*);

    initial begin
        in_clk = 1'b0;
        forever #IN_HALF in_clk = ~in_clk;
    end

    initial begin
        out_clk = 1'b0;
        forever #OUT_HALF out_clk = ~out_clk;
    end

    // ----------------------------------------------------------
    // Helpers and reference model
    // ----------------------------------------------------------

    function automatic logic [31:0] lcg(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic beat_t random_beat();
        beat_t b;
        in_rng = lcg(in_rng);
        b.data = in_rng;
        in_rng = lcg(in_rng);
        b.sop = in_rng[31];
        b.eop = in_rng[30];
        b.empty = in_rng[29:28];
        return b;
    endfunction

    // Oldest accepted beat comes out next, unchanged
    function automatic beat_t expected_beat();
        return sent_q.pop_front();
    endfunction

    function automatic logic [31:0] thresh_readback(input logic [31:0] value);
        return value & ((32'd1 << `DCFIFO_THRESH_W) - 32'd1);
    endfunction

    function automatic logic expected_status(input bit above, input int fill, input int thresh);
        return above ? (fill >= thresh) : (fill <= thresh);
    endfunction

    task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("error at %0d ns: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic csr_write(input bit side, input logic addr, input logic [31:0] value);
        csr_req_t req;
        req = '0;
        req.address = addr;
        req.write = 1'b1;
        req.writedata = value;
        if (side == IN_SIDE) begin
            @(posedge in_clk);
            #2;
            in_csr = req;
            @(posedge in_clk);
            #2;
            in_csr = '0;
        end else begin
            @(posedge out_clk);
            #2;
            out_csr = req;
            @(posedge out_clk);
            #2;
            out_csr = '0;
        end
    endtask

    task automatic csr_read(input bit side, input logic addr, output logic [31:0] data);
        csr_req_t req;
        req = '0;
        req.address = addr;
        req.read = 1'b1;
        if (side == IN_SIDE) begin
            @(posedge in_clk);
            #2;
            in_csr = req;
            @(posedge in_clk);
            #2;
            in_csr = '0;
            data = in_csr_readdata;
        end else begin
            @(posedge out_clk);
            #2;
            out_csr = req;
            @(posedge out_clk);
            #2;
            out_csr = '0;
            data = out_csr_readdata;
        end
    endtask

    task automatic wait_drained();
        while (sent_q.size() != 0) begin
            @(posedge out_clk);
        end
        repeat (20) @(posedge out_clk);
    endtask

    // ----------------------------------------------------------
    // Monitors, output ready and watchdog
    // ----------------------------------------------------------

    always @(posedge in_clk) begin
        if (in_reset_n && in_valid && in_ready) begin
            sent_q.push_back(in_beat);
        end
    end

    always @(posedge out_clk) begin
        if (out_reset_n && out_valid && out_ready) begin
            if (sent_q.size() == 0) begin
                error_count++;
                $display("output beat %h appeared with no accepted input left", out_beat);
            end else begin
                check("output beat", out_beat, expected_beat());
            end
        end
    end

    initial begin
        forever begin
            @(posedge out_clk);
            #2;
            out_rng = lcg(out_rng);
            out_ready = (ready_mode == READY_HIGH)
                     || (ready_mode == READY_RANDOM && out_rng[31]);
        end
    end

    initial begin
        #(2 * TEST_LEN_NS);
        $display("watchdog expired, the test did not complete in the expected time");
        $display("ERRORS FOUND");
        $finish;
    end

    // ----------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------

    initial begin
        logic [31:0] rdata;
        logic [31:0] value;
        int          sent;
        int          accepted;
        int          low_run;
        logic        took;

        in_reset_n = 1'b0;
        out_reset_n = 1'b0;
        in_beat = '0;
        in_valid = 1'b0;
        out_ready = 1'b0;
        in_csr = '0;
        out_csr = '0;
        ready_mode = READY_LOW;
        error_count = 0;
        check_count = 0;
        in_rng = 32'hdad7_9047;
        out_rng = ~32'hdad7_9047;

        // Reset state is checked just before each side leaves reset
        fork
            begin
                repeat (16) @(posedge in_clk);
                #2;
                check("in_ready in reset", in_ready, 1'b1);
                check("almost_full_valid in reset", almost_full_valid, 1'b0);
                in_reset_n = 1'b1;
            end
            begin
                repeat (16) @(posedge out_clk);
                #2;
                check("out_valid in reset", out_valid, 1'b0);
                check("almost_empty_valid in reset", almost_empty_valid, 1'b0);
                out_reset_n = 1'b1;
            end
        join
        csr_read(IN_SIDE, `DCFIFO_ADDR_FILL, rdata);
        check("input fill after reset", rdata, 0);
        csr_read(OUT_SIDE, `DCFIFO_ADDR_FILL, rdata);
        check("output fill after reset", rdata, 0);

        // Threshold registers keep 24 bits
        for (int i = 0; i < 2; i++) begin
            in_rng = lcg(in_rng);
            value = in_rng;
            csr_write(IN_SIDE, `DCFIFO_ADDR_THRESH, value);
            csr_read(IN_SIDE, `DCFIFO_ADDR_THRESH, rdata);
            check("input threshold readback", rdata, thresh_readback(value));
            in_rng = lcg(in_rng);
            value = in_rng;
            csr_write(OUT_SIDE, `DCFIFO_ADDR_THRESH, value);
            csr_read(OUT_SIDE, `DCFIFO_ADDR_THRESH, rdata);
            check("output threshold readback", rdata, thresh_readback(value));
        end

        // Random traffic in both directions
        ready_mode = READY_RANDOM;
        sent = 0;
        @(posedge in_clk);
        #2;
        in_beat = random_beat();
        in_valid = 1'b1;
        while (sent < N_BEATS) begin
            @(posedge in_clk);
            took = in_valid && in_ready;
            #2;
            if (took) begin
                sent++;
                in_beat = random_beat();
            end
            in_rng = lcg(in_rng);
            in_valid = (sent < N_BEATS) && in_rng[31];
        end
        wait_drained();

        // Back-pressure fills memory and the output stage
        ready_mode = READY_LOW;
        repeat (4) @(posedge out_clk);
        @(posedge in_clk);
        #2;
        in_beat = random_beat();
        in_valid = 1'b1;
        accepted = 0;
        low_run = 0;
        while (low_run < 40) begin
            @(posedge in_clk);
            took = in_ready;
            #2;
            if (took) begin
                accepted++;
                low_run = 0;
                in_beat = random_beat();
            end else begin
                low_run++;
            end
        end
        in_valid = 1'b0;
        check("beats accepted under back-pressure", accepted, `DCFIFO_DEPTH + 1);
        repeat (20) @(posedge out_clk);
        csr_read(IN_SIDE, `DCFIFO_ADDR_FILL, rdata);
        check("input fill when full", rdata, `DCFIFO_DEPTH);
        csr_read(OUT_SIDE, `DCFIFO_ADDR_FILL, rdata);
        check("output fill when full", rdata, `DCFIFO_DEPTH + 1);

        // Thresholds below, at and above the settled fill
        for (int i = -1; i <= 1; i++) begin
            csr_write(IN_SIDE, `DCFIFO_ADDR_THRESH, `DCFIFO_DEPTH + i);
            repeat (3) @(posedge in_clk);
            #2;
            check("almost_full_valid", almost_full_valid, 1'b1);
            check("almost_full_data", almost_full_data,
                  expected_status(1'b1, `DCFIFO_DEPTH, `DCFIFO_DEPTH + i));
            csr_write(OUT_SIDE, `DCFIFO_ADDR_THRESH, `DCFIFO_DEPTH + 1 + i);
            repeat (3) @(posedge out_clk);
            #2;
            check("almost_empty_valid", almost_empty_valid, 1'b1);
            check("almost_empty_data", almost_empty_data,
                  expected_status(1'b0, `DCFIFO_DEPTH + 1, `DCFIFO_DEPTH + 1 + i));
        end

        // Drain everything
        ready_mode = READY_HIGH;
        wait_drained();
        check("out_valid after drain", out_valid, 1'b0);
        csr_read(IN_SIDE, `DCFIFO_ADDR_FILL, rdata);
        check("input fill after drain", rdata, 0);
        csr_read(OUT_SIDE, `DCFIFO_ADDR_FILL, rdata);
        check("output fill after drain", rdata, 0);

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: dcfifo_top.f
+incdir+common
common/dcfifo_pkg.sv
hw/gray_ptr_sync.sv
hw/dcfifo_mem.sv
hw/level_csr.sv
hw/write_side/dcfifo_write_ctrl.sv
hw/read_side/dcfifo_read_ctrl.sv
hw/dcfifo_top.sv
test/dcfifo_tb.sv
